// ==== Bender.yml ====
package:
  name: vec_engine

sources:
  - src/vec_pkg.sv
  - src/vector_add.sv
  - src/vector_mul.sv
  - src/op_dispatch.sv
  - src/order_fifo.sv
  - src/result_merge.sv
  - src/vec_engine.sv
  - target: test
    files:
      - tb/vec_checker.sv
      - tb/tb_vec_engine.sv

// ==== src/op_dispatch.sv ====
`timescale 1ns/1ps

module op_dispatch
    import vec_pkg::*;
(
    input  logic                 req_op,
    input  logic [vec_width-1:0] req_a,
    input  logic [vec_width-1:0] req_b,
    input  logic                 req_valid,
    output logic                 req_ready,

    output logic [vec_width-1:0] add_a,
    output logic [vec_width-1:0] add_b,
    output logic                 add_valid,
    input  logic                 add_ready,

    output logic [vec_width-1:0] mul_a,
    output logic [vec_width-1:0] mul_b,
    output logic                 mul_valid,
    input  logic                 mul_ready,

    output logic                 push,
    output logic                 push_tag,
    input  logic                 full
);

    logic sel_mul;
    logic unit_ready;
    logic accept;

    assign sel_mul    = (req_op == op_mul);
    assign unit_ready = sel_mul ? mul_ready : add_ready;

    // a full order queue holds the request back
    assign req_ready = unit_ready && !full;
    assign accept    = req_valid && req_ready;

    // valid goes to the selected unit only, never to both
    assign add_valid = req_valid && !sel_mul && !full;
    assign mul_valid = req_valid && sel_mul && !full;

    // operands fan out to both units
    assign add_a = req_a;
    assign add_b = req_b;
    assign mul_a = req_a;
    assign mul_b = req_b;

    // remember which unit answers this request
    assign push     = accept;
    assign push_tag = req_op;

endmodule

// ==== src/order_fifo.sv ====
`timescale 1ns/1ps

module order_fifo
    import vec_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic push_tag,
    input  logic pop,
    output logic head_tag,
    output logic empty,
    output logic full
);

    logic                  tags [order_depth];
    logic [ptr_width-1:0]  wr_ptr;
    logic [ptr_width-1:0]  rd_ptr;
    logic [fill_width-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            tags[wr_ptr] <= push_tag;
        end
    end

    assign head_tag = tags[rd_ptr];
    assign empty    = (count == 0);
    assign full     = (count == order_depth);

endmodule

// ==== src/result_merge.sv ====
`timescale 1ns/1ps

module result_merge
    import vec_pkg::*;
(
    input  logic                 head_tag,
    input  logic                 empty,
    output logic                 pop,

    input  logic [vec_width-1:0] add_result,
    input  logic                 add_error,
    input  logic                 add_res_valid,
    output logic                 add_res_ready,

    input  logic [vec_width-1:0] mul_result,
    input  logic                 mul_error,
    input  logic                 mul_res_valid,
    output logic                 mul_res_ready,

    output logic [vec_width-1:0] res_data,
    output logic                 res_error,
    output logic                 res_valid,
    input  logic                 res_ready
);

    logic head_mul;
    logic head_valid;

    assign head_mul   = (head_tag == op_mul);
    assign head_valid = head_mul ? mul_res_valid : add_res_valid;

    // only the unit at the queue head is visible on the output
    assign res_valid = !empty && head_valid;
    assign res_data  = head_mul ? mul_result : add_result;
    assign res_error = head_mul ? mul_error : add_error;

    // ready goes back to the head unit alone
    assign add_res_ready = !empty && !head_mul && res_ready;
    assign mul_res_ready = !empty && head_mul && res_ready;

    // finished output transfer retires the head tag
    assign pop = res_valid && res_ready;

endmodule

// ==== src/vec_engine.sv ====
`timescale 1ns/1ps

module vec_engine
    import vec_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_op,
    input  logic [vec_width-1:0] req_a,
    input  logic [vec_width-1:0] req_b,
    input  logic                 req_valid,
    output logic                 req_ready,
    output logic [vec_width-1:0] res_data,
    output logic                 res_error,
    output logic                 res_valid,
    input  logic                 res_ready
);

    logic [vec_width-1:0] add_a;
    logic [vec_width-1:0] add_b;
    logic                 add_valid;
    logic                 add_ready;
    logic [vec_width-1:0] mul_a;
    logic [vec_width-1:0] mul_b;
    logic                 mul_valid;
    logic                 mul_ready;

    logic [vec_width-1:0] add_result;
    logic                 add_error;
    logic                 add_res_valid;
    logic                 add_res_ready;
    logic [vec_width-1:0] mul_result;
    logic                 mul_error;
    logic                 mul_res_valid;
    logic                 mul_res_ready;

    logic                 push;
    logic                 push_tag;
    logic                 full;
    logic                 pop;
    logic                 head_tag;
    logic                 empty;

    op_dispatch u_dispatch (
        .req_op    (req_op),
        .req_a     (req_a),
        .req_b     (req_b),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .add_a     (add_a),
        .add_b     (add_b),
        .add_valid (add_valid),
        .add_ready (add_ready),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .mul_valid (mul_valid),
        .mul_ready (mul_ready),
        .push      (push),
        .push_tag  (push_tag),
        .full      (full)
    );

    vector_add u_add (
        .clk          (clk),
        .rst          (rst),
        .a            (add_a),
        .b            (add_b),
        .in_valid     (add_valid),
        .in_ready     (add_ready),
        .result       (add_result),
        .result_valid (add_res_valid),
        .result_ready (add_res_ready),
        .error        (add_error)
    );

    vector_mul u_mul (
        .clk          (clk),
        .rst          (rst),
        .a            (mul_a),
        .b            (mul_b),
        .in_valid     (mul_valid),
        .in_ready     (mul_ready),
        .result       (mul_result),
        .result_valid (mul_res_valid),
        .result_ready (mul_res_ready),
        .error        (mul_error)
    );

    order_fifo u_order (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push_tag (push_tag),
        .pop      (pop),
        .head_tag (head_tag),
        .empty    (empty),
        .full     (full)
    );

    result_merge u_merge (
        .head_tag      (head_tag),
        .empty         (empty),
        .pop           (pop),
        .add_result    (add_result),
        .add_error     (add_error),
        .add_res_valid (add_res_valid),
        .add_res_ready (add_res_ready),
        .mul_result    (mul_result),
        .mul_error     (mul_error),
        .mul_res_valid (mul_res_valid),
        .mul_res_ready (mul_res_ready),
        .res_data      (res_data),
        .res_error     (res_error),
        .res_valid     (res_valid),
        .res_ready     (res_ready)
    );

endmodule

// ==== src/vec_pkg.sv ====
package vec_pkg;

    // vector geometry
    localparam int vector_len = 4;
    localparam int cell_width = 8;

    // elements handled per cycle, must divide vector_len
    localparam int tiling = 2;

    localparam int vec_width = vector_len * cell_width;

    // element counter inside the units
    localparam int count_width = (vector_len > 1) ? $clog2(vector_len) : 1;

    // opcodes, also used as unit tags in the order queue
    localparam logic op_add = 1'b0;
    localparam logic op_mul = 1'b1;

    // order queue
    localparam int order_depth = 4;
    localparam int ptr_width = (order_depth > 1) ? $clog2(order_depth) : 1;
    localparam int fill_width = $clog2(order_depth + 1);

endpackage

// ==== src/vector_add.sv ====
`timescale 1ns/1ps

module vector_add
    import vec_pkg::*;
#(
    parameter int tiling = vec_pkg::tiling
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [vec_width-1:0] a,
    input  logic [vec_width-1:0] b,
    input  logic                 in_valid,
    output logic                 in_ready,
    output logic [vec_width-1:0] result,
    output logic                 result_valid,
    input  logic                 result_ready,
    output logic                 error
);

    typedef enum logic [1:0] {
        idle,
        calc,
        done
    } state_t;

    state_t                 state;
    logic [vec_width-1:0]   a_q;
    logic [vec_width-1:0]   b_q;
    logic [vec_width-1:0]   result_q;
    logic                   error_q;
    logic [count_width-1:0] counter;
    logic                   last_done;

    logic [cell_width-1:0]  tile_sum [tiling];
    logic [tiling-1:0]      overflow;
    logic [tiling-1:0]      underflow;

    // one signed adder per tile element
    for (genvar i = 0; i < tiling; i++) begin : g_adder
        logic signed [cell_width-1:0] op_a;
        logic signed [cell_width-1:0] op_b;
        logic signed [cell_width:0]   full_sum;

        assign op_a = a_q[(counter + i) * cell_width +: cell_width];
        assign op_b = b_q[(counter + i) * cell_width +: cell_width];
        assign full_sum = op_a + op_b;
        assign tile_sum[i] = full_sum[cell_width-1:0];
        // carry and sign bit disagree when the sum leaves the range
        assign overflow[i] = !full_sum[cell_width] && full_sum[cell_width-1];
        assign underflow[i] = full_sum[cell_width] && !full_sum[cell_width-1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            counter   <= '0;
            last_done <= 1'b0;
            error_q   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (in_valid) begin
                        state     <= calc;
                        counter   <= '0;
                        last_done <= 1'b0;
                        error_q   <= 1'b0;
                    end
                end
                calc: begin
                    if (last_done) begin
                        state <= done;
                    end else begin
                        counter   <= counter + count_width'(tiling);
                        last_done <= (counter == vector_len - tiling);
                        error_q   <= error_q | (|(overflow | underflow));
                    end
                end
                done: begin
                    if (result_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && in_valid) begin
            a_q <= a;
            b_q <= b;
        end
        if (state == calc && !last_done) begin
            for (int t = 0; t < tiling; t++) begin
                result_q[(counter + t) * cell_width +: cell_width] <= tile_sum[t];
            end
        end
    end

    assign in_ready     = (state == idle);
    assign result_valid = (state == done);
    assign result       = result_q;
    assign error        = error_q;

endmodule

// ==== src/vector_mul.sv ====
`timescale 1ns/1ps

module vector_mul
    import vec_pkg::*;
#(
    parameter int tiling = vec_pkg::tiling
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [vec_width-1:0] a,
    input  logic [vec_width-1:0] b,
    input  logic                 in_valid,
    output logic                 in_ready,
    output logic [vec_width-1:0] result,
    output logic                 result_valid,
    input  logic                 result_ready,
    output logic                 error
);

    typedef enum logic [1:0] {
        idle,
        calc,
        done
    } state_t;

    state_t                 state;
    logic [vec_width-1:0]   a_q;
    logic [vec_width-1:0]   b_q;
    logic [vec_width-1:0]   result_q;
    logic                   error_q;
    logic [count_width-1:0] counter;
    logic                   last_done;

    logic [cell_width-1:0]  tile_prod [tiling];
    logic [tiling-1:0]      trunc_err;

    // one signed multiplier per tile element
    for (genvar i = 0; i < tiling; i++) begin : g_mult
        logic signed [cell_width-1:0]   op_a;
        logic signed [cell_width-1:0]   op_b;
        logic signed [2*cell_width-1:0] full_prod;

        assign op_a = a_q[(counter + i) * cell_width +: cell_width];
        assign op_b = b_q[(counter + i) * cell_width +: cell_width];
        assign full_prod = op_a * op_b;
        assign tile_prod[i] = full_prod[cell_width-1:0];
        // upper bits must all copy the sign of the kept part
        assign trunc_err[i] = (full_prod[2*cell_width-1:cell_width-1] !=
                               {(cell_width + 1){full_prod[cell_width-1]}});
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            counter   <= '0;
            last_done <= 1'b0;
            error_q   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (in_valid) begin
                        state     <= calc;
                        counter   <= '0;
                        last_done <= 1'b0;
                        error_q   <= 1'b0;
                    end
                end
                calc: begin
                    if (last_done) begin
                        state <= done;
                    end else begin
                        counter   <= counter + count_width'(tiling);
                        last_done <= (counter == vector_len - tiling);
                        error_q   <= error_q | (|trunc_err);
                    end
                end
                done: begin
                    if (result_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && in_valid) begin
            a_q <= a;
            b_q <= b;
        end
        if (state == calc && !last_done) begin
            for (int t = 0; t < tiling; t++) begin
                result_q[(counter + t) * cell_width +: cell_width] <= tile_prod[t];
            end
        end
    end

    assign in_ready     = (state == idle);
    assign result_valid = (state == done);
    assign result       = result_q;
    assign error        = error_q;

endmodule

// ==== tb/tb_vec_engine.sv ====
`timescale 1ns/1ps

module tb_vec_engine
    import vec_pkg::*;
();

    localparam string data_file = "tb/vec_testdata.txt";
    localparam int clk_period = 40;

    logic                 clk;
    logic                 rst;
    logic                 req_op;
    logic [vec_width-1:0] req_a;
    logic [vec_width-1:0] req_b;
    logic                 req_valid;
    logic                 req_ready;
    logic [vec_width-1:0] res_data;
    logic                 res_error;
    logic                 res_valid;
    logic                 res_ready;

    logic                 op_list [$];
    logic [vec_width-1:0] a_list [$];
    logic [vec_width-1:0] b_list [$];
    int                   num_tests;
    bit                   loaded = 1'b0;
    integer               seed;
    logic                 checks_done;
    int                   pass_count;
    int                   fail_count;

    always #(clk_period / 2) clk = ~clk;

    vec_engine dut (
        .clk       (clk),
        .rst       (rst),
        .req_op    (req_op),
        .req_a     (req_a),
        .req_b     (req_b),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .res_data  (res_data),
        .res_error (res_error),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    vec_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .res_data    (res_data),
        .res_error   (res_error),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .checks_done (checks_done),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    // operands only, the checker reads the expected columns
    task automatic load_requests();
        int                   fd;
        int                   n;
        string                line;
        logic [3:0]           op_v;
        logic [vec_width-1:0] a_v;
        logic [vec_width-1:0] b_v;
        logic [vec_width-1:0] exp_v;
        logic [3:0]           err_v;
        fd = $fopen(data_file, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h", op_v, a_v, b_v, exp_v, err_v);
                    if (n == 5) begin
                        op_list.push_back(op_v[0]);
                        a_list.push_back(a_v);
                        b_list.push_back(b_v);
                    end
                end
            end
            $fclose(fd);
        end
        num_tests = op_list.size();
    endtask

    // result back-pressure, ready about three cycles in four
    always @(posedge clk) begin
        res_ready <= (($random(seed) & 3) != 0);
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req_op    = op_add;
        req_a     = '0;
        req_b     = '0;
        req_valid = 1'b0;
        res_ready = 1'b0;
        seed      = 57111;
        load_requests();
        if (num_tests == 0) begin
            $display("no tests could be read from %s", data_file);
            $display("=== FAIL ===");
        end else begin
            loaded = 1'b1;
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            // a few idle cycles for the after-reset check
            repeat (3) @(posedge clk);
            for (int i = 0; i < num_tests; i++) begin
                req_op    <= op_list[i];
                req_a     <= a_list[i];
                req_b     <= b_list[i];
                req_valid <= 1'b1;
                @(posedge clk);
                while (!req_ready) begin
                    @(posedge clk);
                end
            end
            req_valid <= 1'b0;
            wait (checks_done);
            // extra cycles to catch a duplicated result
            repeat (10) @(posedge clk);
            $display("tests passed %0d, failed %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #(num_tests * 20 * clk_period);
        $display("timeout: not all results arrived within %0d cycles", num_tests * 20);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== tb/vec_checker.sv ====
`timescale 1ns/1ps

module vec_checker
    import vec_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  logic                 req_ready,
    input  logic [vec_width-1:0] res_data,
    input  logic                 res_error,
    input  logic                 res_valid,
    input  logic                 res_ready,
    output logic                 checks_done,
    output int                   pass_count,
    output int                   fail_count
);

    localparam string data_file = "tb/vec_testdata.txt";

    logic                 exp_op [$];
    logic [vec_width-1:0] exp_data [$];
    logic                 exp_err [$];
    int                   got;
    bit                   idle_seen;
    bit                   idle_ok;
    bit                   held;
    logic [vec_width-1:0] held_data;
    logic                 held_error;
    bit                   ok;

    initial begin
        int                   fd;
        int                   n;
        string                line;
        logic [3:0]           op_v;
        logic [vec_width-1:0] a_v;
        logic [vec_width-1:0] b_v;
        logic [vec_width-1:0] exp_v;
        logic [3:0]           err_v;
        checks_done = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        got         = 0;
        idle_seen   = 1'b0;
        idle_ok     = 1'b1;
        held        = 1'b0;
        fd = $fopen(data_file, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h", op_v, a_v, b_v, exp_v, err_v);
                    if (n == 5) begin
                        exp_op.push_back(op_v[0]);
                        exp_data.push_back(exp_v);
                        exp_err.push_back(err_v[0]);
                    end
                end
            end
            $fclose(fd);
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            // engine idle until the first request
            if (!idle_seen) begin
                if (res_valid !== 1'b0) begin
                    $display("** Error: res_valid after reset expected %h actual %h",
                             1'b0, res_valid);
                    idle_ok = 1'b0;
                end
                if (req_ready !== 1'b1) begin
                    $display("** Error: req_ready after reset expected %h actual %h",
                             1'b1, req_ready);
                    idle_ok = 1'b0;
                end
                if (req_valid) begin
                    idle_seen = 1'b1;
                    $display("test reset idle: %s", idle_ok ? "ok" : "failed");
                    if (idle_ok) begin
                        pass_count++;
                    end else begin
                        fail_count++;
                    end
                end
            end

            // a result waiting for ready must not move
            if (held) begin
                if (!res_valid) begin
                    $display("res_valid dropped while a result was waiting for ready");
                    fail_count++;
                end else if (res_data !== held_data || res_error !== held_error) begin
                    $display("** Error: res_data held expected %h actual %h, res_error %h %h",
                             held_data, res_data, held_error, res_error);
                    fail_count++;
                end
            end
            held       = res_valid && !res_ready;
            held_data  = res_data;
            held_error = res_error;

            if (res_valid && res_ready) begin
                if (got >= exp_data.size()) begin
                    $display("result %h arrived after the last test", res_data);
                    fail_count++;
                end else begin
                    ok = 1'b1;
                    if (res_data !== exp_data[got]) begin
                        $display("** Error: test %0d res_data expected %h actual %h",
                                 got + 1, exp_data[got], res_data);
                        ok = 1'b0;
                    end
                    if (res_error !== exp_err[got]) begin
                        $display("** Error: test %0d res_error expected %h actual %h",
                                 got + 1, exp_err[got], res_error);
                        ok = 1'b0;
                    end
                    $display("test %0d %s: %s", got + 1,
                             (exp_op[got] == op_mul) ? "mul" : "add", ok ? "ok" : "failed");
                    if (ok) begin
                        pass_count++;
                    end else begin
                        fail_count++;
                    end
                    got++;
                    if (got == exp_data.size()) begin
                        checks_done = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== tb/vec_testdata.txt ====
# columns: op a b expected_result expected_error, all hex
# op 0 is add and 1 is multiply, element 0 is the lowest byte of each vector
0 01020304 10203040 11223344 0
0 FFFE807F 01FE7F80 00FCFFFF 0
0 6410F005 6401F0FB C811E000 1
0 80007F01 FF000002 7F007F03 1
1 0203FC0A 05F9FD0C 0AEB0C78 0
1 1002FF00 1003FF55 00060100 1
1 80017F0B FF7F010B 807F7F79 1
1 8000F609 0133F6F2 80006482 0
0 11111111 22222222 33333333 0
1 03030303 04040404 0C0C0C0C 0
0 7F7F7F7F 01000100 807F807F 1
1 F0F0F0F0 08080808 80808080 0
0 0A0B0C0D F6F5F4F3 00000000 0
1 0F0E0D0C 09090A0B 877E8284 1
0 C0C0C0C0 C0C0C0BF 8080807F 1
1 FFFFFFFF FFFFFFFF 01010101 0
0 00000000 00000000 00000000 0
1 7F7F0000 7F010000 017F0000 1
0 12345678 87654321 99999999 1
1 02020202 40C03F81 80807E02 1

// ==== vec_engine.f ====
src/vec_pkg.sv
src/vector_add.sv
src/vector_mul.sv
src/op_dispatch.sv
src/order_fifo.sv
src/result_merge.sv
src/vec_engine.sv
tb/vec_checker.sv
tb/tb_vec_engine.sv
